// File: common/csr_cfg.svh
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// machine trap setup and handling
`define CSR_ADDR_MSTATUS   12'h300
`define CSR_ADDR_MISA      12'h301
`define CSR_ADDR_MIE       12'h304
`define CSR_ADDR_MTVEC     12'h305
`define CSR_ADDR_MSCRATCH  12'h340
`define CSR_ADDR_MEPC      12'h341
`define CSR_ADDR_MCAUSE    12'h342
`define CSR_ADDR_MTVAL     12'h343

// machine counters
`define CSR_ADDR_MCYCLE    12'hB00
`define CSR_ADDR_MINSTRET  12'hB02
`define CSR_ADDR_MCYCLEH   12'hB80
`define CSR_ADDR_MINSTRETH 12'hB82

// user-mode read-only aliases
`define CSR_ADDR_CYCLE     12'hC00
`define CSR_ADDR_TIME      12'hC01
`define CSR_ADDR_INSTRET   12'hC02
`define CSR_ADDR_CYCLEH    12'hC80
`define CSR_ADDR_TIMEH     12'hC81
`define CSR_ADDR_INSTRETH  12'hC82

// write operations, 2'b11 is never issued
`define CSR_OP_RW 2'b00
`define CSR_OP_RS 2'b01
`define CSR_OP_RC 2'b10

`define CSR_SRC_IMM 1'b0
`define CSR_SRC_REG 1'b1

// MXL=1 (32 bit), only the I extension
`define MISA_VALUE 32'h4000_0100

`define MCAUSE_ECALL_M    4'b1011
`define MCAUSE_BREAKPOINT 4'b0011

// only machine mode exists
`define MSTATUS_MPP_M 2'b11

`endif

// File: common/csr_pkg.sv
package csr_pkg;

    // request from the execute stage
    typedef struct packed {
        logic        read;
        logic        write;
        logic [1:0]  write_op;
        logic        src;
        logic [11:0] addr;
        logic [31:0] rs1_value;
        logic [31:0] imm_value;
    } csr_req_t;

    typedef struct packed {
        logic        ecall;
        logic        ebreak;
        logic        mret;
        logic [31:0] pc;
    } trap_req_t;

    typedef struct packed {
        logic [18:0] reserved_hi;
        logic [1:0]  mpp;
        logic [2:0]  reserved_mid;
        logic        mpie;
        logic [2:0]  reserved_lo;
        logic        mie;
        logic [2:0]  reserved_low;
    } mstatus_bits_t;

    typedef struct packed {
        logic [19:0] reserved_hi;
        logic        meie;
        logic [2:0]  reserved_mid;
        logic        mtie;
        logic [2:0]  reserved_lo;
        logic        msie;
        logic [2:0]  reserved_low;
    } mie_bits_t;

    typedef struct packed {
        logic [29:0] base;
        logic        reserved;
        logic        mode;
    } mtvec_bits_t;

    typedef struct packed {
        logic        interrupt;
        logic [26:0] reserved;
        logic [3:0]  code;
    } mcause_bits_t;

    // one CSR word, seen through the layout of the addressed register
    typedef union packed {
        logic [31:0]   raw;
        mstatus_bits_t mstatus;
        mie_bits_t     mie;
        mtvec_bits_t   mtvec;
        mcause_bits_t  mcause;
    } csr_word_u;

    typedef struct packed {
        logic        write;
        logic [11:0] addr;
        csr_word_u   data;
    } csr_wr_t;

    typedef struct packed {
        logic        mstatus_mpie;
        logic        mstatus_mie;
        logic        mie_meie;
        logic        mie_mtie;
        logic        mie_msie;
        logic [29:0] mtvec_base;
        logic        mtvec_mode;
        logic [31:0] mscratch;
        logic [29:0] mepc;
        logic        mcause_interrupt;
        logic [3:0]  mcause_code;
        logic [31:0] mtval;
    } machine_state_t;

    typedef struct packed {
        logic [63:0] cycle;
        logic [63:0] instret;
    } counter_state_t;

endpackage

// File: csr/csr_access.sv
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_access (
    input  csr_pkg::csr_req_t       csr_req,
    input  csr_pkg::machine_state_t machine_state,
    input  csr_pkg::counter_state_t counters,
    output logic [31:0]             read_value,
    output csr_pkg::csr_wr_t        csr_wr
);
    import csr_pkg::*;

    csr_word_u   rd_word;
    logic [31:0] write_value;
    logic [31:0] new_value;

    always_comb begin
        rd_word.raw = '0;
        case (csr_req.addr)
            `CSR_ADDR_MSTATUS: begin
                rd_word.mstatus.mpp  = `MSTATUS_MPP_M;
                rd_word.mstatus.mpie = machine_state.mstatus_mpie;
                rd_word.mstatus.mie  = machine_state.mstatus_mie;
            end
            `CSR_ADDR_MISA:     rd_word.raw = `MISA_VALUE;
            `CSR_ADDR_MIE: begin
                rd_word.mie.meie = machine_state.mie_meie;
                rd_word.mie.mtie = machine_state.mie_mtie;
                rd_word.mie.msie = machine_state.mie_msie;
            end
            `CSR_ADDR_MTVEC: begin
                rd_word.mtvec.base = machine_state.mtvec_base;
                rd_word.mtvec.mode = machine_state.mtvec_mode;
            end
            `CSR_ADDR_MSCRATCH: rd_word.raw = machine_state.mscratch;
            `CSR_ADDR_MEPC:     rd_word.raw = {machine_state.mepc, 2'b00};
            `CSR_ADDR_MCAUSE: begin
                rd_word.mcause.interrupt = machine_state.mcause_interrupt;
                rd_word.mcause.code      = machine_state.mcause_code;
            end
            `CSR_ADDR_MTVAL:    rd_word.raw = machine_state.mtval;
            // time has no separate timer, it mirrors cycle
            `CSR_ADDR_MCYCLE,
            `CSR_ADDR_CYCLE,
            `CSR_ADDR_TIME:     rd_word.raw = counters.cycle[31:0];
            `CSR_ADDR_MCYCLEH,
            `CSR_ADDR_CYCLEH,
            `CSR_ADDR_TIMEH:    rd_word.raw = counters.cycle[63:32];
            `CSR_ADDR_MINSTRET,
            `CSR_ADDR_INSTRET:  rd_word.raw = counters.instret[31:0];
            `CSR_ADDR_MINSTRETH,
            `CSR_ADDR_INSTRETH: rd_word.raw = counters.instret[63:32];
            default:            rd_word.raw = '0;
        endcase
    end

    assign read_value  = rd_word.raw;
    assign write_value = (csr_req.src == `CSR_SRC_REG) ? csr_req.rs1_value : csr_req.imm_value;

    always_comb begin
        case (csr_req.write_op)
            `CSR_OP_RS: new_value = read_value | write_value;
            `CSR_OP_RC: new_value = read_value & ~write_value;
            default:    new_value = write_value;
        endcase
    end

    assign csr_wr.write    = csr_req.write;
    assign csr_wr.addr     = csr_req.addr;
    assign csr_wr.data.raw = new_value;

    // op 2'b11 has no meaning and must never reach the registers
    always_comb begin
        if (csr_req.write) begin
            assert (csr_req.write_op != 2'b11);
        end
    end

endmodule

// File: csr/perf_counters.sv
`timescale 1ns/1ps

module perf_counters (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    instr_retired,
    input  logic                    writeback_flush,
    output csr_pkg::counter_state_t counters
);

    logic retire;

    // a flushed writeback did not really retire
    assign retire = instr_retired && !writeback_flush;

    // counts even while the pipeline is stalled
    always_ff @(posedge clk) begin
        if (reset) begin
            counters <= '0;
        end else begin
            counters.cycle   <= counters.cycle + 64'd1;
            counters.instret <= counters.instret + {63'd0, retire};
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        !$past(reset) |-> counters.cycle == $past(counters.cycle) + 64'd1);

endmodule

// File: csr/rv32_csr_unit.sv
`timescale 1ns/1ps

module rv32_csr_unit (
    input  logic               clk,
    input  logic               reset,
    input  logic               stall,
    input  logic               flush,
    input  logic               writeback_flush,
    input  logic               instr_retired,
    input  csr_pkg::csr_req_t  csr_req,
    input  csr_pkg::trap_req_t trap_req,
    output logic [31:0]        read_value,
    output logic               trap,
    output logic [31:0]        trap_pc,
    output logic [63:0]        cycle
);
    import csr_pkg::*;

    machine_state_t machine_state;
    counter_state_t counters;
    csr_wr_t        csr_wr;

    // decode and read mux, purely combinational
    csr_access csr_access_inst (
        .csr_req       (csr_req),
        .machine_state (machine_state),
        .counters      (counters),
        .read_value    (read_value),
        .csr_wr        (csr_wr)
    );

    trap_regs trap_regs_inst (
        .clk           (clk),
        .reset         (reset),
        .stall         (stall),
        .flush         (flush),
        .csr_wr        (csr_wr),
        .trap_req      (trap_req),
        .machine_state (machine_state),
        .trap          (trap),
        .trap_pc       (trap_pc)
    );

    perf_counters perf_counters_inst (
        .clk             (clk),
        .reset           (reset),
        .instr_retired   (instr_retired),
        .writeback_flush (writeback_flush),
        .counters        (counters)
    );

    assign cycle = counters.cycle;

endmodule

// File: csr/trap_regs.sv
`timescale 1ns/1ps
`include "csr_cfg.svh"

module trap_regs (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    stall,
    input  logic                    flush,
    input  csr_pkg::csr_wr_t        csr_wr,
    input  csr_pkg::trap_req_t      trap_req,
    output csr_pkg::machine_state_t machine_state,
    output logic                    trap,
    output logic [31:0]             trap_pc
);

    logic advance;
    logic exception;

    assign advance   = !stall && !flush;
    assign exception = trap_req.ecall || trap_req.ebreak;

    // redirect target, mtvec mode is stored but never vectors
    always_comb begin
        trap    = 1'b0;
        trap_pc = '0;
        if (advance) begin
            if (exception) begin
                trap    = 1'b1;
                trap_pc = {machine_state.mtvec_base, 2'b00};
            end else if (trap_req.mret) begin
                trap    = 1'b1;
                trap_pc = {machine_state.mepc, 2'b00};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            machine_state <= '0;
        end else if (advance) begin
            if (csr_wr.write) begin
                case (csr_wr.addr)
                    `CSR_ADDR_MSTATUS: begin
                        machine_state.mstatus_mpie <= csr_wr.data.mstatus.mpie;
                        machine_state.mstatus_mie  <= csr_wr.data.mstatus.mie;
                    end
                    `CSR_ADDR_MIE: begin
                        machine_state.mie_meie <= csr_wr.data.mie.meie;
                        machine_state.mie_mtie <= csr_wr.data.mie.mtie;
                        machine_state.mie_msie <= csr_wr.data.mie.msie;
                    end
                    `CSR_ADDR_MTVEC: begin
                        machine_state.mtvec_base <= csr_wr.data.mtvec.base;
                        machine_state.mtvec_mode <= csr_wr.data.mtvec.mode;
                    end
                    `CSR_ADDR_MSCRATCH: machine_state.mscratch <= csr_wr.data.raw;
                    `CSR_ADDR_MEPC:     machine_state.mepc <= csr_wr.data.raw[31:2];
                    `CSR_ADDR_MCAUSE: begin
                        machine_state.mcause_interrupt <= csr_wr.data.mcause.interrupt;
                        machine_state.mcause_code      <= csr_wr.data.mcause.code;
                    end
                    `CSR_ADDR_MTVAL:    machine_state.mtval <= csr_wr.data.raw;
                    default: begin
                    end
                endcase
            end

            // assigned last so a trap beats a csr write in the same cycle
            if (exception) begin
                machine_state.mepc             <= trap_req.pc[31:2];
                machine_state.mcause_interrupt <= 1'b0;
                if (trap_req.ecall) begin
                    machine_state.mcause_code <= `MCAUSE_ECALL_M;
                end else begin
                    machine_state.mcause_code <= `MCAUSE_BREAKPOINT;
                end
            end else if (trap_req.mret) begin
                machine_state.mstatus_mie  <= machine_state.mstatus_mpie;
                machine_state.mstatus_mpie <= 1'b1;
            end
        end
    end

    // decode upstream raises at most one exception per instruction
    assert property (@(posedge clk) disable iff (reset)
        !(trap_req.ecall && trap_req.ebreak));

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps -f src.f \
    --top-module tb_rv32_csr_unit -o sim_tb
output=$(./obj_dir/sim_tb)
echo "$output"
echo "$output" | grep -qx "sim passed"

// File: src.f
+incdir+common
common/csr_pkg.sv
csr/csr_access.sv
csr/trap_regs.sv
csr/perf_counters.sv
csr/rv32_csr_unit.sv
verification/tb_clock_gen.sv
verification/tb_rv32_csr_unit.sv

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // released 1 ns after the third rising edge
    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

// File: verification/tb_rv32_csr_unit.sv
`timescale 1ns/1ps
`include "csr_cfg.svh"

module tb_rv32_csr_unit;
    import csr_pkg::*;

    localparam int MSTATUS = 0;
    localparam int MTVEC   = 2;
    localparam int MEPC    = 4;
    localparam int MCAUSE  = 5;

    logic        clk;
    logic        reset;
    logic        stall;
    logic        flush;
    logic        writeback_flush;
    logic        instr_retired;
    csr_req_t    csr_req;
    trap_req_t   trap_req;
    logic [31:0] read_value;
    logic        trap;
    logic [31:0] trap_pc;
    logic [63:0] cycle;

    // writable registers in order mstatus mie mtvec mscratch mepc mcause mtval
    logic [11:0] reg_addr [7];
    logic [31:0] reg_mask [7];
    logic [31:0] model_regs [7];
    logic [63:0] exp_cycle;
    logic [63:0] exp_instret;
    logic [15:0] lfsr_state;
    int          error_count;
    int          tests_run;
    int          tests_failed;

    tb_clock_gen clock_gen_inst (.clk(clk), .reset(reset));

    rv32_csr_unit rv32_csr_unit_inst (.*);

    always @(posedge clk) begin
        if (reset) begin
            exp_cycle   <= '0;
            exp_instret <= '0;
        end else begin
            exp_cycle <= exp_cycle + 64'd1;
            if (instr_retired && !writeback_flush) exp_instret <= exp_instret + 64'd1;
        end
    end

    // fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic logic [31:0] model_read(input logic [11:0] addr);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < 7; i++) begin
            if (reg_addr[i] == addr) value = model_regs[i];
        end
        case (addr)
            `CSR_ADDR_MSTATUS: value = value | {19'd0, `MSTATUS_MPP_M, 11'd0};
            `CSR_ADDR_MISA: value = `MISA_VALUE;
            `CSR_ADDR_MCYCLE, `CSR_ADDR_CYCLE, `CSR_ADDR_TIME: value = exp_cycle[31:0];
            `CSR_ADDR_MCYCLEH, `CSR_ADDR_CYCLEH, `CSR_ADDR_TIMEH: value = exp_cycle[63:32];
            `CSR_ADDR_MINSTRET, `CSR_ADDR_INSTRET: value = exp_instret[31:0];
            `CSR_ADDR_MINSTRETH, `CSR_ADDR_INSTRETH: value = exp_instret[63:32];
            default: ;
        endcase
        return value;
    endfunction

    task automatic model_write(input int idx, input logic [1:0] op, input logic [31:0] value);
        logic [31:0] result;
        result = model_read(reg_addr[idx]);
        case (op)
            `CSR_OP_RS: result = result | value;
            `CSR_OP_RC: result = result & ~value;
            default: result = value;
        endcase
        model_regs[idx] = result & reg_mask[idx];
    endtask

    task automatic compare(input string what, input logic [31:0] got,
                           input logic [31:0] expected);
        if (got !== expected) begin
            $display("mismatch at %0t: %s is %08h, expected %08h", $time, what, got, expected);
            error_count++;
        end
    endtask

    // requests last one cycle
    task automatic next_cycle();
        @(posedge clk);
        #1;
        csr_req  = '0;
        trap_req = '0;
        stall    = 1'b0;
        flush    = 1'b0;
    endtask

    task automatic read_back(input logic [11:0] addr, input string what);
        next_cycle();
        csr_req.read = 1'b1;
        csr_req.addr = addr;
        @(negedge clk);
        compare(what, read_value, model_read(addr));
        compare("trap without request", {31'd0, trap}, 32'd0);
    endtask

    // blocked means stall or flush high plus a random trap request
    task automatic write_random(input int idx, input logic blocked);
        logic [31:0] r;
        logic [31:0] value;
        next_cycle();
        r = rand_bits(3);
        csr_req.read      = 1'b1;
        csr_req.write     = 1'b1;
        csr_req.write_op  = (r[1:0] == 2'b11) ? `CSR_OP_RW : r[1:0];
        csr_req.src       = r[2];
        csr_req.addr      = reg_addr[idx];
        csr_req.rs1_value = rand_bits(32);
        csr_req.imm_value = rand_bits(5);
        if (blocked) begin
            r = rand_bits(4);
            stall           = !r[1] || r[0];
            flush           = r[1];
            trap_req.ecall  = (r[3:2] == 2'd1);
            trap_req.ebreak = (r[3:2] == 2'd2);
            trap_req.mret   = (r[3:2] == 2'd3);
            trap_req.pc     = rand_bits(32);
        end
        value = (csr_req.src == `CSR_SRC_REG) ? csr_req.rs1_value : csr_req.imm_value;
        @(negedge clk);
        compare("value before write", read_value, model_read(reg_addr[idx]));
        if (blocked) begin
            compare("trap while blocked", {31'd0, trap}, 32'd0);
        end else begin
            model_write(idx, csr_req.write_op, value);
        end
    endtask

    // kind is 0 for ecall, 1 for ebreak and 2 for mret
    task automatic issue_trap(input int kind);
        logic [31:0] pc;
        logic [31:0] target;
        next_cycle();
        pc = rand_bits(32);
        trap_req.ecall  = (kind == 0);
        trap_req.ebreak = (kind == 1);
        trap_req.mret   = (kind == 2);
        trap_req.pc     = pc;
        target = (kind == 2) ? model_regs[MEPC] : (model_regs[MTVEC] & 32'hFFFF_FFFC);
        @(negedge clk);
        compare("trap", {31'd0, trap}, 32'd1);
        compare("trap_pc", trap_pc, target);
        if (kind == 2) begin
            // mie takes the old mpie and mpie goes to one
            model_regs[MSTATUS] = 32'h80 | (model_regs[MSTATUS][7] ? 32'h8 : 32'h0);
        end else begin
            model_regs[MEPC]   = pc & reg_mask[MEPC];
            model_regs[MCAUSE] = (kind == 0) ? {28'd0, `MCAUSE_ECALL_M} :
                                               {28'd0, `MCAUSE_BREAKPOINT};
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, error_count - errors_before);
        end
    endtask

    initial begin
        int          start;
        int          cycles;
        int          idx;
        logic [31:0] r;
        lfsr_state      = 16'd53777;
        error_count     = 0;
        tests_run       = 0;
        tests_failed    = 0;
        reg_addr   = '{`CSR_ADDR_MSTATUS, `CSR_ADDR_MIE, `CSR_ADDR_MTVEC, `CSR_ADDR_MSCRATCH,
                       `CSR_ADDR_MEPC, `CSR_ADDR_MCAUSE, `CSR_ADDR_MTVAL};
        reg_mask   = '{32'h0000_0088, 32'h0000_0888, 32'hFFFF_FFFD, 32'hFFFF_FFFF,
                       32'hFFFF_FFFC, 32'h8000_000F, 32'hFFFF_FFFF};
        model_regs = '{default: 32'd0};
        csr_req         = '0;
        trap_req        = '0;
        stall           = 1'b0;
        flush           = 1'b0;
        writeback_flush = 1'b0;
        instr_retired   = 1'b0;

        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (reset && cycles < 20);

        if (reset) begin
            $display("timeout: reset still high after %0d cycles", cycles);
            error_count++;
        end else begin
            start = error_count;
            compare("cycle after reset", cycle[31:0], 32'd0);
            for (int i = 0; i < 7; i++) read_back(reg_addr[i], "reset value");
            read_back(`CSR_ADDR_MISA, "misa");
            read_back(12'h7C0, "unknown address");
            finish_test("reset values", start);

            start = error_count;
            repeat (300) begin
                r = rand_bits(3);
                idx = r % 7;
                write_random(idx, 1'b0);
                read_back(reg_addr[idx], "read after write");
            end
            finish_test("random writes", start);

            start = error_count;
            repeat (40) begin
                write_random(MTVEC, 1'b0);
                r = rand_bits(1);
                issue_trap(r % 2);
                read_back(`CSR_ADDR_MEPC, "mepc after trap");
                read_back(`CSR_ADDR_MCAUSE, "mcause after trap");
            end
            finish_test("ecall and ebreak", start);

            start = error_count;
            repeat (40) begin
                write_random(MSTATUS, 1'b0);
                write_random(MEPC, 1'b0);
                issue_trap(2);
                read_back(`CSR_ADDR_MSTATUS, "mstatus after mret");
            end
            finish_test("mret", start);

            start = error_count;
            repeat (60) begin
                r = rand_bits(3);
                idx = r % 7;
                write_random(idx, 1'b1);
                read_back(reg_addr[idx], "register after blocked write");
            end
            for (int i = 0; i < 7; i++) read_back(reg_addr[i], "register after blocked traps");
            finish_test("stall and flush", start);

            // counter, alias and unused counter-space addresses
            start = error_count;
            repeat (200) begin
                next_cycle();
                r = rand_bits(6);
                instr_retired   = r[0];
                writeback_flush = r[1];
                csr_req.read    = 1'b1;
                csr_req.addr    = {r[5] ? 4'hC : 4'hB, r[4] ? 4'h8 : 4'h0, 2'b00, r[3:2]};
                @(negedge clk);
                compare("cycle port low", cycle[31:0], exp_cycle[31:0]);
                compare("cycle port high", cycle[63:32], exp_cycle[63:32]);
                compare("counter read", read_value, model_read(csr_req.addr));
            end
            next_cycle();
            instr_retired   = 1'b0;
            writeback_flush = 1'b0;
            finish_test("counters", start);
        end

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
